/* rtl/rvCorePkg.sv */
// RV32I core package with ISA constants, control enums and pipeline bundles
`default_nettype none

package rvCorePkg;

    localparam int XLEN = 32;
    localparam logic [31:0] NOP_INST = 32'h0000_0013; // ADDI x0, x0, 0

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        JAL    = 7'b1101111
    } opcodeE;

    typedef enum logic [3:0] {ADD, SUB, AND, OR, XOR, SLT} aluOpE;

    typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwdSelE;

    typedef struct packed {
        logic  regWrite;
        logic  memToReg;
        logic  memRead;
        logic  memWrite;
        logic  aluSrc;   // Immediate as operand B
        logic  rwSel;    // Write decode-time rdData
        logic  branch;
        logic  jump;
        aluOpE aluOp;
    } ctrlT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
    } ifIdT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [XLEN-1:0] rData1;
        logic [XLEN-1:0] rData2;
        logic [XLEN-1:0] imm32;
        logic [XLEN-1:0] rdData;
        logic [XLEN-1:0] pc;
    } idExT;

    typedef struct packed {
        ctrlT            ctrl;
        logic [4:0]      rd;
        logic [2:0]      funct3;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] rData2;   // Store data after forwarding
        logic [XLEN-1:0] rdData;
    } exMemT;

    typedef struct packed {
        logic            regWrite;
        logic            memToReg;
        logic            rwSel;
        logic [4:0]      rd;
        logic [XLEN-1:0] rdData;
        logic [XLEN-1:0] aluResult;
        logic [XLEN-1:0] rData;
    } memWbT;

    typedef struct packed {
        logic            re;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } dmemReqT;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic [XLEN-1:0] data;
    } retireT;

endpackage

`default_nettype wire

/* rtl/pipelineRegs.sv */
// Stage registers between fetch, decode, execute, memory and writeback
`timescale 1ns/10ps
`default_nettype none

module ifIdReg (
    input  logic              clk,
    input  logic              rstN,
    input  logic              hold,
    input  logic              flush,
    input  rvCorePkg::ifIdT   d,
    output rvCorePkg::ifIdT   q
);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q.pc   <= '0;
            q.inst <= rvCorePkg::NOP_INST;
        end else if (flush) begin
            q.pc   <= d.pc;
            q.inst <= rvCorePkg::NOP_INST; // Squash the fetched slot
        end else if (!hold) begin
            q <= d;
        end
    end

endmodule

module idExReg (
    input  logic              clk,
    input  logic              rstN,
    input  logic              bubble,
    input  rvCorePkg::idExT   d,
    output rvCorePkg::idExT   q
);

    rvCorePkg::ctrlT ctrlQ;
    rvCorePkg::idExT dataQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= bubble ? '0 : d.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        dataQ <= d;
    end

    always_comb begin
        q      = dataQ;
        q.ctrl = ctrlQ;
    end

endmodule

module exMemReg (
    input  logic              clk,
    input  logic              rstN,
    input  rvCorePkg::exMemT  d,
    output rvCorePkg::exMemT  q
);

    rvCorePkg::ctrlT  ctrlQ;
    rvCorePkg::exMemT dataQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= d.ctrl;
        end
    end

    always_ff @(posedge clk) begin
        dataQ <= d;
    end

    always_comb begin
        q      = dataQ;
        q.ctrl = ctrlQ;
    end

endmodule

module memWbReg (
    input  logic              clk,
    input  logic              rstN,
    input  rvCorePkg::memWbT  d,
    output rvCorePkg::memWbT  q
);

    logic [2:0]       ctrlQ; // regWrite, memToReg, rwSel
    rvCorePkg::memWbT dataQ;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlQ <= '0;
        end else begin
            ctrlQ <= {d.regWrite, d.memToReg, d.rwSel};
        end
    end

    // Load data is captured here too
    always_ff @(posedge clk) begin
        dataQ <= d;
    end

    always_comb begin
        q          = dataQ;
        q.regWrite = ctrlQ[2];
        q.memToReg = ctrlQ[1];
        q.rwSel    = ctrlQ[0];
    end

endmodule

`default_nettype wire

/* rtl/decoder.sv */
// Instruction decoder producing control bits, register indexes and immediates
`timescale 1ns/10ps
`default_nettype none

module decoder (
    input  logic [31:0]                inst,
    output rvCorePkg::ctrlT            ctrl,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic [4:0]                 rd,
    output logic [2:0]                 funct3,
    output logic [rvCorePkg::XLEN-1:0] imm32,
    output logic [rvCorePkg::XLEN-1:0] luiValue
);

    rvCorePkg::opcodeE opcode;
    rvCorePkg::aluOpE  aluFn;
    logic              fnValid;
    logic              useRs1;
    logic              useRs2;
    logic [31:0]       immI, immS, immB, immU, immJ;

    assign opcode = rvCorePkg::opcodeE'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign rd     = inst[11:7];
    assign rs1    = useRs1 ? inst[19:15] : 5'd0; // Unused fields never cause a stall
    assign rs2    = useRs2 ? inst[24:20] : 5'd0;

    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immU = {inst[31:12], 12'b0};
    assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign luiValue = immU;

    // funct3 to ALU op, SUB only for R-type
    always_comb begin
        fnValid = 1'b1;
        case (funct3)
            3'b000: begin
                if (opcode == rvCorePkg::OP && inst[30]) begin
                    aluFn = rvCorePkg::SUB;
                end else begin
                    aluFn = rvCorePkg::ADD;
                end
            end
            3'b010: aluFn = rvCorePkg::SLT;
            3'b100: aluFn = rvCorePkg::XOR;
            3'b110: aluFn = rvCorePkg::OR;
            3'b111: aluFn = rvCorePkg::AND;
            default: begin
                aluFn   = rvCorePkg::ADD;
                fnValid = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl   = '0;
        useRs1 = 1'b0;
        useRs2 = 1'b0;
        imm32  = '0;
        case (opcode)
            rvCorePkg::OP: begin
                useRs1        = 1'b1;
                useRs2        = 1'b1;
                ctrl.regWrite = fnValid;
                ctrl.aluOp    = aluFn;
            end
            rvCorePkg::OP_IMM: begin
                useRs1        = 1'b1;
                imm32         = immI;
                ctrl.regWrite = fnValid;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluFn;
            end
            rvCorePkg::LOAD: begin
                useRs1        = 1'b1;
                imm32         = immI;
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            rvCorePkg::STORE: begin
                useRs1        = 1'b1;
                useRs2        = 1'b1;
                imm32         = immS;
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
            end
            rvCorePkg::BRANCH: begin
                useRs1      = 1'b1;
                useRs2      = 1'b1;
                imm32       = immB;
                ctrl.branch = (funct3[2:1] == 2'b00); // BEQ and BNE only
                ctrl.aluOp  = rvCorePkg::SUB;
            end
            rvCorePkg::LUI: begin
                imm32         = immU;
                ctrl.regWrite = 1'b1;
                ctrl.rwSel    = 1'b1;
            end
            rvCorePkg::JAL: begin
                imm32         = immJ;
                ctrl.regWrite = 1'b1;
                ctrl.rwSel    = 1'b1; // Link value comes from decode
                ctrl.jump     = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Register file with two read ports, one write port and write-to-read bypass
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       we,
    input  logic [4:0]                 wAddr,
    input  logic [4:0]                 rAddr1,
    input  logic [4:0]                 rAddr2,
    input  logic [rvCorePkg::XLEN-1:0] wData,
    output logic [rvCorePkg::XLEN-1:0] rData1,
    output logic [rvCorePkg::XLEN-1:0] rData2
);

    logic [rvCorePkg::XLEN-1:0] regs [0:31];

    function automatic logic [rvCorePkg::XLEN-1:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return '0;
        end else if (we && (wAddr == addr)) begin
            return wData; // Writeback in the same cycle
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wAddr != 5'd0)) begin
            regs[wAddr] <= wData;
        end
    end

    assign rData1 = readPort(rAddr1);
    assign rData2 = readPort(rAddr2);

endmodule

`default_nettype wire

/* rtl/alu.sv */
// ALU for the integer subset and the BEQ/BNE comparison
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  rvCorePkg::aluOpE           op,
    input  logic [rvCorePkg::XLEN-1:0] a,
    input  logic [rvCorePkg::XLEN-1:0] b,
    input  logic [2:0]                 funct3,
    output logic [rvCorePkg::XLEN-1:0] result,
    output logic                       branchTaken
);

    logic equal;

    assign equal       = (a == b);
    assign branchTaken = funct3[0] ? !equal : equal; // BNE : BEQ

    always_comb begin
        case (op)
            rvCorePkg::ADD: result = a + b;
            rvCorePkg::SUB: result = a - b;
            rvCorePkg::AND: result = a & b;
            rvCorePkg::OR:  result = a | b;
            rvCorePkg::XOR: result = a ^ b;
            rvCorePkg::SLT: begin
                // Signed compare
                result = {{(rvCorePkg::XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            end
            default: result = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/hazardUnit.sv */
// Load-use stall detection and operand forwarding selection
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  logic [4:0]        idRs1,
    input  logic [4:0]        idRs2,
    input  logic [4:0]        exRs1,
    input  logic [4:0]        exRs2,
    input  logic [4:0]        exRd,
    input  logic [4:0]        memRd,
    input  logic [4:0]        wbRd,
    input  logic              exMemRead,
    input  logic              memRegWrite,
    input  logic              wbRegWrite,
    output logic              loadUseStall,
    output rvCorePkg::fwdSelE fwdA,
    output rvCorePkg::fwdSelE fwdB
);

    // Younger producer in EX/MEM wins over MEM/WB
    function automatic rvCorePkg::fwdSelE fwdSel(input logic [4:0] rs);
        if (memRegWrite && (memRd != 5'd0) && (memRd == rs)) begin
            return rvCorePkg::FWD_MEM;
        end else if (wbRegWrite && (wbRd != 5'd0) && (wbRd == rs)) begin
            return rvCorePkg::FWD_WB;
        end
        return rvCorePkg::FWD_REG;
    endfunction

    assign fwdA = fwdSel(exRs1);
    assign fwdB = fwdSel(exRs2);

    // Load in execute feeding the instruction in decode
    assign loadUseStall = exMemRead && (exRd != 5'd0)
                          && ((exRd == idRs1) || (exRd == idRs2));

endmodule

`default_nettype wire

/* rtl/rvCore.sv */
// Five-stage in-order RV32I subset core with forwarding and load-use stall
`timescale 1ns/10ps
`default_nettype none

module rvCore (
    input  logic                       clk,
    input  logic                       rstN,
    output logic [rvCorePkg::XLEN-1:0] imemAddr,
    input  logic [31:0]                imemData,
    output rvCorePkg::dmemReqT         dmemReq,
    input  logic [rvCorePkg::XLEN-1:0] dmemRData,
    output rvCorePkg::retireT          retire
);

    localparam int W = rvCorePkg::XLEN;

    logic [W-1:0]      pc, pcNext, target;
    rvCorePkg::ifIdT   ifIdD, ifIdQ;
    rvCorePkg::idExT   idExD, idExQ;
    rvCorePkg::exMemT  exMemD, exMemQ;
    rvCorePkg::memWbT  memWbD, memWbQ;
    rvCorePkg::ctrlT   idCtrl;
    logic [4:0]        idRs1, idRs2, idRd;
    logic [2:0]        idFunct3;
    logic [W-1:0]      idImm, luiValue, rData1, rData2;
    logic              loadUseStall, redirect, branchTaken;
    rvCorePkg::fwdSelE fwdA, fwdB;
    logic [W-1:0]      opA, opB, aluB, aluResult, memFwd, wbData;

    function automatic logic [W-1:0] fwdMux(input rvCorePkg::fwdSelE sel,
                                            input logic [W-1:0] regVal);
        case (sel)
            rvCorePkg::FWD_MEM: return memFwd;
            rvCorePkg::FWD_WB:  return wbData;
            default:            return regVal;
        endcase
    endfunction

    // Fetch
    assign target   = idExQ.pc + idExQ.imm32;
    assign redirect = idExQ.ctrl.jump || (idExQ.ctrl.branch && branchTaken);

    always_comb begin
        if (redirect) begin
            pcNext = target;
        end else if (loadUseStall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + W'(4);
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

    assign imemAddr = pc;
    assign ifIdD    = '{pc: pc, inst: imemData};

    ifIdReg u_ifIdReg (.clk(clk), .rstN(rstN), .hold(loadUseStall), .flush(redirect),
                       .d(ifIdD), .q(ifIdQ));

    // Decode
    decoder u_decoder (.inst(ifIdQ.inst), .ctrl(idCtrl), .rs1(idRs1), .rs2(idRs2), .rd(idRd),
                       .funct3(idFunct3), .imm32(idImm), .luiValue(luiValue));

    regFile u_regFile (.clk(clk), .rstN(rstN), .we(memWbQ.regWrite), .wAddr(memWbQ.rd),
                       .rAddr1(idRs1), .rAddr2(idRs2), .wData(wbData),
                       .rData1(rData1), .rData2(rData2));

    always_comb begin
        idExD.ctrl   = idCtrl;
        idExD.rs1    = idRs1;
        idExD.rs2    = idRs2;
        idExD.rd     = idRd;
        idExD.funct3 = idFunct3;
        idExD.rData1 = rData1;
        idExD.rData2 = rData2;
        idExD.imm32  = idImm;
        idExD.rdData = idCtrl.jump ? ifIdQ.pc + W'(4) : luiValue; // Link or upper immediate
        idExD.pc     = ifIdQ.pc;
    end

    idExReg u_idExReg (.clk(clk), .rstN(rstN), .bubble(loadUseStall || redirect),
                       .d(idExD), .q(idExQ));

    hazardUnit u_hazardUnit (.idRs1(idRs1), .idRs2(idRs2), .exRs1(idExQ.rs1),
                             .exRs2(idExQ.rs2), .exRd(idExQ.rd), .memRd(exMemQ.rd),
                             .wbRd(memWbQ.rd), .exMemRead(idExQ.ctrl.memRead),
                             .memRegWrite(exMemQ.ctrl.regWrite), .wbRegWrite(memWbQ.regWrite),
                             .loadUseStall(loadUseStall), .fwdA(fwdA), .fwdB(fwdB));

    // Execute
    assign opA  = fwdMux(fwdA, idExQ.rData1);
    assign opB  = fwdMux(fwdB, idExQ.rData2); // Also the store data
    assign aluB = idExQ.ctrl.aluSrc ? idExQ.imm32 : opB;

    alu u_alu (.op(idExQ.ctrl.aluOp), .a(opA), .b(aluB), .funct3(idExQ.funct3),
               .result(aluResult), .branchTaken(branchTaken));

    assign exMemD = '{ctrl: idExQ.ctrl, rd: idExQ.rd, funct3: idExQ.funct3,
                      aluResult: aluResult, rData2: opB, rdData: idExQ.rdData};

    exMemReg u_exMemReg (.clk(clk), .rstN(rstN), .d(exMemD), .q(exMemQ));

    // Memory
    assign dmemReq = '{re: exMemQ.ctrl.memRead, we: exMemQ.ctrl.memWrite,
                       addr: exMemQ.aluResult, wdata: exMemQ.rData2};
    assign memFwd  = exMemQ.ctrl.rwSel ? exMemQ.rdData : exMemQ.aluResult;

    assign memWbD = '{regWrite: exMemQ.ctrl.regWrite, memToReg: exMemQ.ctrl.memToReg,
                      rwSel: exMemQ.ctrl.rwSel, rd: exMemQ.rd, rdData: exMemQ.rdData,
                      aluResult: exMemQ.aluResult, rData: dmemRData};

    memWbReg u_memWbReg (.clk(clk), .rstN(rstN), .d(memWbD), .q(memWbQ));

    // Writeback
    always_comb begin
        if (memWbQ.rwSel) begin
            wbData = memWbQ.rdData;
        end else if (memWbQ.memToReg) begin
            wbData = memWbQ.rData;
        end else begin
            wbData = memWbQ.aluResult;
        end
    end

    assign retire = '{valid: memWbQ.regWrite && (memWbQ.rd != 5'd0), rd: memWbQ.rd,
                      data: wbData};

endmodule

`default_nettype wire

/* verif/tbCore.sv */
// Testbench for the pipelined RV32I subset core with an ISA reference model
`timescale 1ns/10ps
`default_nettype none

module tbCore;

    logic                       clk = 1'b0;
    logic                       rstN;
    logic [rvCorePkg::XLEN-1:0] imemAddr;
    logic [31:0]                imemData;
    rvCorePkg::dmemReqT         dmemReq;
    logic [rvCorePkg::XLEN-1:0] dmemRData;
    rvCorePkg::retireT          retire;

    logic [31:0]        imem [0:255];
    logic [31:0]        dmem [0:255]; // 1 KB, word index from addr[9:2]
    int                 instTest [0:255];
    int                 progLen;
    int                 curTest;
    integer             seed;
    int                 cycles = 0;
    int                 limit;
    logic [31:0]        endPc;
    rvCorePkg::retireT  expRetire[$];
    rvCorePkg::dmemReqT expMem[$];
    string              expRetireName[$];
    string              expMemName[$];

    always #4 clk = ~clk;

    assign imemData  = imem[imemAddr[9:2]];
    assign dmemRData = dmem[dmemReq.addr[9:2]];

    rvCore u_rvCore (.clk(clk), .rstN(rstN), .imemAddr(imemAddr), .imemData(imemData),
                     .dmemReq(dmemReq), .dmemRData(dmemRData), .retire(retire));

    always @(posedge clk) begin
        if (dmemReq.we) begin
            dmem[dmemReq.addr[9:2]] <= dmemReq.wdata;
        end
    end

    function automatic logic [31:0] encR(input logic [4:0] rd, rs1, rs2,
                                         input logic [2:0] f3, input logic sub);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, rvCorePkg::OP};
    endfunction

    function automatic logic [31:0] encI(input logic [4:0] rd, rs1, input logic [11:0] imm,
                                         input logic [2:0] f3, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [4:0] rs2, rs1, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvCorePkg::STORE};
    endfunction

    function automatic logic [31:0] encB(input logic [4:0] rs1, rs2, input logic [12:0] imm,
                                         input logic bne);
        return {imm[12], imm[10:5], rs2, rs1, 2'b00, bne, imm[4:1], imm[11], rvCorePkg::BRANCH};
    endfunction

    function automatic logic [31:0] encU(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, rvCorePkg::LUI};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvCorePkg::JAL};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return encI(rd, rs1, imm, 3'b000, rvCorePkg::OP_IMM);
    endfunction

    function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return encI(rd, rs1, imm, 3'b010, rvCorePkg::LOAD);
    endfunction

    function automatic string testName(input int t);
        case (t)
            0:       return "aluChain";
            1:       return "loadUse";
            2:       return "stores";
            3:       return "branches";
            4:       return "luiJal";
            default: return "x0Reset";
        endcase
    endfunction

    // ISA semantics of the integer ops
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, b);
        case (f3)
            3'b000:  return sub ? a - b : a + b;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // Runs the program at ISA level and queues the expected events in order
    function automatic int runModel();
        logic [31:0]        regs [0:31];
        logic [31:0]        mem [0:255];
        logic [31:0]        pc, inst, a, b, res, addr, nextPc;
        logic [4:0]         rd;
        logic               wr;
        rvCorePkg::retireT  ret;
        rvCorePkg::dmemReqT st;
        int                 i;
        int                 count;
        for (i = 0; i < 32; i++) begin
            regs[i[4:0]] = '0;
        end
        for (i = 0; i < 256; i++) begin
            mem[i[7:0]] = dmem[i[7:0]];
        end
        pc = '0;
        count = 0;
        while (imem[pc[9:2]] != encJ(5'd0, 21'd0) && count < 4096) begin
            inst   = imem[pc[9:2]];
            rd     = inst[11:7];
            a      = regs[inst[19:15]];
            b      = regs[inst[24:20]];
            wr     = 1'b0;
            res    = '0;
            nextPc = pc + 32'd4;
            case (inst[6:0])
                rvCorePkg::OP: begin
                    wr  = 1'b1;
                    res = aluRef(inst[14:12], inst[30], a, b);
                end
                rvCorePkg::OP_IMM: begin
                    wr  = 1'b1;
                    res = aluRef(inst[14:12], 1'b0, a, {{20{inst[31]}}, inst[31:20]});
                end
                rvCorePkg::LOAD: begin
                    wr   = 1'b1;
                    addr = a + {{20{inst[31]}}, inst[31:20]};
                    res  = mem[addr[9:2]];
                    st.re    = 1'b1;
                    st.we    = 1'b0;
                    st.addr  = addr;
                    st.wdata = '0;
                    expMem.push_back(st);
                    expMemName.push_back(testName(instTest[pc[9:2]]));
                end
                rvCorePkg::STORE: begin
                    addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
                    mem[addr[9:2]] = b;
                    st.re    = 1'b0;
                    st.we    = 1'b1;
                    st.addr  = addr;
                    st.wdata = b;
                    expMem.push_back(st);
                    expMemName.push_back(testName(instTest[pc[9:2]]));
                end
                rvCorePkg::BRANCH: begin
                    if ((a == b) != inst[12]) begin // funct3 bit 0 picks BNE
                        nextPc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                    end
                end
                rvCorePkg::LUI: begin
                    wr  = 1'b1;
                    res = {inst[31:12], 12'b0};
                end
                rvCorePkg::JAL: begin
                    wr     = 1'b1;
                    res    = pc + 32'd4;
                    nextPc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                end
                default: ;
            endcase
            if (wr && rd != 5'd0) begin
                regs[rd]  = res;
                ret.valid = 1'b1;
                ret.rd    = rd;
                ret.data  = res;
                expRetire.push_back(ret);
                expRetireName.push_back(testName(instTest[pc[9:2]]));
            end
            pc = nextPc;
            count++;
        end
        endPc = pc;
        return count;
    endfunction

    task automatic emit(input logic [31:0] inst);
        imem[progLen[7:0]]     = inst;
        instTest[progLen[7:0]] = curTest;
        progLen = progLen + 1;
    endtask

    // Each op reads the last two results, so both forwarding paths get used
    task automatic genAluChain(input int n);
        int         k;
        logic [4:0] rd;
        logic [4:0] lastRd;
        logic [4:0] prevRd;
        logic [2:0] f3;
        lastRd = 5'd0;
        prevRd = 5'd0;
        for (k = 0; k < n; k++) begin
            rd = 5'd1 + 5'($unsigned($random(seed)) % 15);
            case ($unsigned($random(seed)) % 5)
                0:       f3 = 3'b000;
                1:       f3 = 3'b010;
                2:       f3 = 3'b100;
                3:       f3 = 3'b110;
                default: f3 = 3'b111;
            endcase
            if (k < 2 || $random(seed) % 2 == 0) begin
                emit(encI(rd, lastRd, 12'($random(seed)), f3, rvCorePkg::OP_IMM));
            end else begin
                emit(encR(rd, lastRd, prevRd, f3, f3 == 3'b000 && $random(seed) % 2 == 0));
            end
            prevRd = lastRd;
            lastRd = rd;
        end
    endtask

    task automatic buildProgram();
        curTest = 0;
        genAluChain(40);
        curTest = 1;
        emit(addi(5'd16, 5'd0, 12'h040));
        emit(lw(5'd17, 5'd16, 12'h000));
        emit(encR(5'd18, 5'd17, 5'd17, 3'b000, 1'b0)); // Consumer right behind the load
        emit(lw(5'd19, 5'd16, 12'h004));
        emit(encR(5'd18, 5'd1, 5'd19, 3'b000, 1'b1));
        emit(lw(5'd20, 5'd16, 12'h008));
        emit(encI(5'd21, 5'd20, 12'h0ff, 3'b111, rvCorePkg::OP_IMM));
        curTest = 2;
        emit(addi(5'd20, 5'd0, 12'h080));
        emit(addi(5'd21, 5'd1, 12'h005));
        emit(encS(5'd21, 5'd20, 12'h000)); // Data from EX/MEM, address from MEM/WB
        emit(addi(5'd20, 5'd20, 12'h008));
        emit(encS(5'd17, 5'd20, 12'hffc));
        emit(lw(5'd22, 5'd20, 12'hff8)); // Reads the first store back
        emit(encR(5'd23, 5'd22, 5'd21, 3'b100, 1'b0));
        emit(lw(5'd24, 5'd20, 12'hffc));
        emit(encS(5'd24, 5'd16, 12'h00c));
        curTest = 3;
        emit(addi(5'd24, 5'd0, 12'h007));
        emit(addi(5'd25, 5'd0, 12'h007));
        emit(encB(5'd24, 5'd25, 13'd12, 1'b0)); // BEQ taken
        emit(addi(5'd26, 5'd0, 12'h001));
        emit(encS(5'd26, 5'd16, 12'h010)); // Squashed store
        emit(encB(5'd24, 5'd25, 13'd8, 1'b1)); // BNE not taken
        emit(addi(5'd28, 5'd24, 12'h003));
        emit(encB(5'd24, 5'd0, 13'd12, 1'b1));
        emit(addi(5'd27, 5'd0, 12'h001));
        emit(addi(5'd26, 5'd0, 12'h002));
        emit(encB(5'd28, 5'd0, 13'd8, 1'b0));
        emit(addi(5'd29, 5'd28, 12'h001));
        emit(addi(5'd9, 5'd0, 12'h003));
        emit(addi(5'd9, 5'd9, 12'hfff)); // Countdown loop
        emit(encB(5'd9, 5'd0, 13'h1ffc, 1'b1));
        curTest = 4;
        emit(encU(5'd30, 20'habcde));
        emit(addi(5'd6, 5'd30, 12'h001));
        emit(encJ(5'd31, 21'd12));
        emit(addi(5'd26, 5'd0, 12'h003));
        emit(addi(5'd27, 5'd0, 12'h003));
        emit(encR(5'd5, 5'd31, 5'd30, 3'b000, 1'b0));
        emit(encJ(5'd0, 21'd8));
        emit(addi(5'd27, 5'd0, 12'h004));
        emit(encR(5'd11, 5'd5, 5'd6, 3'b110, 1'b0));
        curTest = 5;
        emit(addi(5'd0, 5'd0, 12'h037));
        emit(encR(5'd0, 5'd1, 5'd2, 3'b000, 1'b0));
        emit(encR(5'd7, 5'd0, 5'd0, 3'b110, 1'b0));
        emit(addi(5'd8, 5'd0, 12'hfff));
        emit(lw(5'd0, 5'd16, 12'h000));
        emit(encR(5'd10, 5'd0, 5'd8, 3'b000, 1'b0));
        emit(encJ(5'd0, 21'd0)); // Final loop
    endtask

    task automatic abortRun();
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic checkRetire(input rvCorePkg::retireT act);
        rvCorePkg::retireT exp;
        string             name;
        if (expRetire.size() == 0) begin
            $display("Retire of x%0d = %h came after the last expected event", act.rd, act.data);
            abortRun();
        end else begin
            exp  = expRetire.pop_front();
            name = expRetireName.pop_front();
            if (act.rd !== exp.rd || act.data !== exp.data) begin
                $display("[FAIL] %s retire expected x%0d=%h actual x%0d=%h",
                         name, exp.rd, exp.data, act.rd, act.data);
                abortRun();
            end
        end
    endtask

    // Store data only counts for writes
    task automatic checkMemReq(input rvCorePkg::dmemReqT act);
        rvCorePkg::dmemReqT exp;
        string              name;
        if (expMem.size() == 0) begin
            $display("Memory access re=%b we=%b at %h was not expected",
                     act.re, act.we, act.addr);
            abortRun();
        end else begin
            exp  = expMem.pop_front();
            name = expMemName.pop_front();
            if (act.re !== exp.re || act.we !== exp.we || act.addr !== exp.addr
                || (exp.we && act.wdata !== exp.wdata)) begin
                $display("[FAIL] %s memory expected re=%b we=%b [%h]=%h actual re=%b we=%b [%h]=%h",
                         name, exp.re, exp.we, exp.addr, exp.wdata,
                         act.re, act.we, act.addr, act.wdata);
                abortRun();
            end
        end
    endtask

    always @(posedge clk) begin
        if (rstN && retire.valid) begin
            checkRetire(retire);
        end
    end

    always @(posedge clk) begin
        if (rstN && (dmemReq.re || dmemReq.we)) begin
            checkMemReq(dmemReq);
        end
    end

    always @(negedge clk) begin
        if (!rstN && (retire.valid || dmemReq.we || dmemReq.re)) begin
            $display("Retire or memory strobe went high while reset was held");
            abortRun();
        end
    end

    always @(posedge clk) begin
        if (rstN) begin
            cycles <= cycles + 1;
        end
        if (cycles > limit) begin
            $display("Timeout after %0d cycles with %0d retires and %0d accesses outstanding",
                     cycles, expRetire.size(), expMem.size());
            abortRun();
        end
    end

    initial begin
        int i;
        rstN    = 1'b0;
        seed    = 64;
        progLen = 0;
        for (i = 0; i < 256; i++) begin
            imem[i[7:0]]     = addi(5'(1 + i % 31), 5'd0, 12'(i)); // Stray fetches would retire
            dmem[i[7:0]]     = {16'hD5A0 ^ 16'(i), 16'(i << 2)};
            instTest[i[7:0]] = 5;
        end
        buildProgram();
        limit = 3 * runModel() + 50;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
        while (imemAddr != endPc) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk); // Squashed slots of the final loop stay silent
        if (expRetire.size() == 0 && expMem.size() == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Final loop reached with %0d retires and %0d accesses never seen",
                     expRetire.size(), expMem.size());
            abortRun();
        end
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/rvCorePkg.sv
rtl/pipelineRegs.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/hazardUnit.sv
rtl/rvCore.sv
verif/tbCore.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

LOG=sim.log

verilator --binary --timing --timescale 1ns/10ps --top-module tbCore \
    -Mdir obj_dir -o simCore -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simCore > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

grep -qx "PASS: all tests" "$LOG"
if [ $? -ne 0 ]; then
    echo "Pass line not found in $LOG"
    exit 1
fi
exit 0
